// File: design/hyperram_pkg.sv
package hyperram_pkg;

	// host data and address word
	typedef logic [31:0] word_t;
	// one byte on the dq lines
	typedef logic [7:0] byte_t;
	// byte select mask for memory writes
	typedef logic [3:0] sel_t;
	// command-address word, sent as six bytes
	typedef logic [47:0] ca_t;
	// run-time phase timings (tcsh, tpre, tacc, tpost)
	typedef logic [3:0] tim_t;
	// read timeout in bus clock periods
	typedef logic [4:0] tmo_t;
	// phase cycle counter, also carries the latency value
	typedef logic [5:0] cnt_t;
	// bytes still expected in a read
	typedef logic [2:0] rcnt_t;

	// bus phases
	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_PRE     = 3'd1,
		S_CA      = 3'd2,
		S_LATENCY = 3'd3,
		S_WRITE   = 3'd4,
		S_READ    = 3'd5,
		S_POST    = 3'd6
	} bus_state_e;

	// lowest accepted tacc and read timeout
	localparam int MIN_TACC = 2;
	localparam int MIN_TIMEOUT = 4;

	// byte counts per phase
	localparam int CA_BYTES = 6;
	localparam int MEM_BYTES = 4;
	localparam int REG_BYTES = 2;

	// command-address bit positions
	localparam int CA_READ_BIT = 47;
	localparam int CA_REG_BIT = 46;
	localparam int CA_LINEAR_BIT = 45;

endpackage

// File: design/hb_timing_cfg.sv
`timescale 1ns/100ps

module hb_timing_cfg (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                load_i,
	input  hyperram_pkg::tim_t  tcsh_i,
	input  hyperram_pkg::tim_t  tacc_i,
	input  hyperram_pkg::tim_t  tpost_i,
	input  hyperram_pkg::tmo_t  trmax_i,
	input  logic                fixed_latency_i,
	input  logic                double_latency_i,
	input  logic                read_op_i,
	input  logic                rwds_2x_i,
	output hyperram_pkg::tim_t  tcsh_o,
	output hyperram_pkg::tim_t  tpost_o,
	output hyperram_pkg::cnt_t  latency_o,
	output hyperram_pkg::cnt_t  read_tmo_o
);

	hyperram_pkg::tim_t tcsh_r;
	hyperram_pkg::tim_t tacc_r;
	hyperram_pkg::tim_t tpost_r;
	hyperram_pkg::tmo_t tmo_r;
	logic fixed_r;
	logic double_r;
	logic lat_double;
	hyperram_pkg::cnt_t lat_base;

	// per-operation copy, taken on the cycle the sequencer leaves idle
	always_ff @(posedge clk_i) begin
		if (load_i) begin
			tcsh_r <= tcsh_i;
			tpost_r <= tpost_i;
			// tacc and timeout never go below what the device needs
			tacc_r <= (tacc_i >= hyperram_pkg::tim_t'(hyperram_pkg::MIN_TACC)) ?
				tacc_i : hyperram_pkg::tim_t'(hyperram_pkg::MIN_TACC);
			tmo_r <= (trmax_i >= hyperram_pkg::tmo_t'(hyperram_pkg::MIN_TIMEOUT)) ?
				trmax_i : hyperram_pkg::tmo_t'(hyperram_pkg::MIN_TIMEOUT);
			fixed_r <= fixed_latency_i;
			double_r <= double_latency_i;
		end
	end

	// fixed latency ignores rwds, variable latency follows the CA-phase sample
	assign lat_double = fixed_r ? double_r : rwds_2x_i;

	always_comb begin
		// 4*tacc or 2*tacc bus half-periods
		lat_base = lat_double ? {tacc_r, 2'b00} : {1'b0, tacc_r, 1'b0};
		// writes start one cycle sooner, reads need the extra cycle for dq turnaround
		latency_o = lat_base - hyperram_pkg::cnt_t'(2) - {5'b00000, ~read_op_i};
	end

	// timeout counted in clk_i cycles, two per bus clock
	assign read_tmo_o = {tmo_r, 1'b0} - hyperram_pkg::cnt_t'(2);
	assign tcsh_o = tcsh_r;
	assign tpost_o = tpost_r;

	// clamped values hold from the load onwards
	a_clamped: assert property (@(posedge clk_i) disable iff (rst_i)
		load_i |=> (tacc_r >= hyperram_pkg::tim_t'(hyperram_pkg::MIN_TACC))
			&& (tmo_r >= hyperram_pkg::tmo_t'(hyperram_pkg::MIN_TIMEOUT)));

endmodule

// File: design/hb_sequencer.sv
`timescale 1ns/100ps

module hb_sequencer #(
	parameter int DEFAULT_TCSH = 4
) (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     valid_i,
	input  logic                     wren_i,
	input  logic                     regspace_i,
	input  hyperram_pkg::word_t      addr_i,
	input  hyperram_pkg::word_t      data_i,
	input  hyperram_pkg::sel_t       sel_i,
	input  hyperram_pkg::tim_t       tpre_i,
	input  hyperram_pkg::tim_t       tcsh_i,
	input  hyperram_pkg::tim_t       tpost_i,
	input  hyperram_pkg::cnt_t       latency_i,
	input  hyperram_pkg::cnt_t       read_tmo_i,
	input  logic                     read_done_i,
	output hyperram_pkg::bus_state_e state_o,
	output hyperram_pkg::cnt_t       cycle_cnt_o,
	output hyperram_pkg::ca_t        ca_o,
	output hyperram_pkg::word_t      wdata_o,
	output hyperram_pkg::sel_t       sel_o,
	output logic                     load_o,
	output logic                     ready_o,
	output logic                     read_timeout_o
);

	// last counter value of each fixed-length phase
	localparam hyperram_pkg::cnt_t CA_LAST = hyperram_pkg::cnt_t'(hyperram_pkg::CA_BYTES - 1);
	localparam hyperram_pkg::cnt_t MEM_LAST = hyperram_pkg::cnt_t'(hyperram_pkg::MEM_BYTES - 1);
	localparam hyperram_pkg::cnt_t REG_LAST = hyperram_pkg::cnt_t'(hyperram_pkg::REG_BYTES - 1);

	hyperram_pkg::bus_state_e state_r;
	hyperram_pkg::cnt_t cycle_cnt_r;
	hyperram_pkg::ca_t ca_r;
	hyperram_pkg::word_t wdata_r;
	hyperram_pkg::sel_t sel_r;
	logic valid_r;
	logic busy_r;
	logic read_timeout_r;
	logic valid_start;
	logic accept;
	logic start_op;
	logic cnt_zero;
	logic read_op;
	logic reg_access;

	// host must drop valid_i between operations, only the edge counts
	assign valid_start = valid_i && !valid_r;
	assign accept = valid_start && !busy_r;
	assign cnt_zero = (cycle_cnt_r == '0);
	// tcsh done and something to do, either new or queued
	assign start_op = (state_r == hyperram_pkg::S_IDLE) && cnt_zero && (busy_r || valid_start);
	assign read_op = ca_r[hyperram_pkg::CA_READ_BIT];
	assign reg_access = ca_r[hyperram_pkg::CA_REG_BIT];

	// operands of the accepted operation
	always_ff @(posedge clk_i) begin
		if (accept) begin
			wdata_r <= data_i;
			sel_r <= sel_i;
			ca_r[hyperram_pkg::CA_READ_BIT] <= ~wren_i;
			ca_r[hyperram_pkg::CA_REG_BIT] <= regspace_i;
			// always linear bursts
			ca_r[hyperram_pkg::CA_LINEAR_BIT] <= 1'b1;
			ca_r[44:16] <= addr_i[31:3];
			ca_r[15:3] <= '0;
			ca_r[2:0] <= addr_i[2:0];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r <= hyperram_pkg::S_IDLE;
			// first idle period still honours a minimum cs high time
			cycle_cnt_r <= hyperram_pkg::cnt_t'(DEFAULT_TCSH);
			valid_r <= 1'b0;
			busy_r <= 1'b0;
			read_timeout_r <= 1'b0;
		end else begin
			valid_r <= valid_i;
			case (state_r)
				hyperram_pkg::S_IDLE: begin
					// count down tcsh while waiting
					if (!cnt_zero)
						cycle_cnt_r <= cycle_cnt_r - 1'b1;
					// busy from now, may still sit here until tcsh runs out
					if (accept) begin
						busy_r <= 1'b1;
						read_timeout_r <= 1'b0;
					end
					if (start_op) begin
						state_r <= hyperram_pkg::S_PRE;
						cycle_cnt_r <= hyperram_pkg::cnt_t'(tpre_i);
					end
				end
				hyperram_pkg::S_PRE: begin
					// cs low before the first clock edge
					if (!cnt_zero) begin
						cycle_cnt_r <= cycle_cnt_r - 1'b1;
					end else begin
						state_r <= hyperram_pkg::S_CA;
						cycle_cnt_r <= CA_LAST;
					end
				end
				hyperram_pkg::S_CA: begin
					if (!cnt_zero) begin
						cycle_cnt_r <= cycle_cnt_r - 1'b1;
					end else if (!read_op && reg_access) begin
						// register writes have no latency
						state_r <= hyperram_pkg::S_WRITE;
						cycle_cnt_r <= REG_LAST;
					end else begin
						state_r <= hyperram_pkg::S_LATENCY;
						cycle_cnt_r <= latency_i;
					end
				end
				hyperram_pkg::S_LATENCY: begin
					if (!cnt_zero) begin
						cycle_cnt_r <= cycle_cnt_r - 1'b1;
					end else if (read_op) begin
						// counter turns into the read timeout
						state_r <= hyperram_pkg::S_READ;
						cycle_cnt_r <= read_tmo_i;
					end else begin
						state_r <= hyperram_pkg::S_WRITE;
						cycle_cnt_r <= MEM_LAST;
					end
				end
				hyperram_pkg::S_WRITE: begin
					if (!cnt_zero) begin
						cycle_cnt_r <= cycle_cnt_r - 1'b1;
					end else begin
						state_r <= hyperram_pkg::S_POST;
						cycle_cnt_r <= hyperram_pkg::cnt_t'(tpost_i);
					end
				end
				hyperram_pkg::S_READ: begin
					if (cnt_zero || read_done_i) begin
						state_r <= hyperram_pkg::S_POST;
						cycle_cnt_r <= hyperram_pkg::cnt_t'(tpost_i);
						// device never strobed all bytes
						read_timeout_r <= cnt_zero && !read_done_i;
					end else begin
						cycle_cnt_r <= cycle_cnt_r - 1'b1;
					end
				end
				hyperram_pkg::S_POST: begin
					// last clock edge to cs high
					if (!cnt_zero) begin
						cycle_cnt_r <= cycle_cnt_r - 1'b1;
					end else begin
						state_r <= hyperram_pkg::S_IDLE;
						cycle_cnt_r <= hyperram_pkg::cnt_t'(tcsh_i);
						busy_r <= 1'b0;
					end
				end
				default: begin
					state_r <= hyperram_pkg::S_IDLE;
				end
			endcase
		end
	end

	assign state_o = state_r;
	assign cycle_cnt_o = cycle_cnt_r;
	assign ca_o = ca_r;
	assign wdata_o = wdata_r;
	assign sel_o = sel_r;
	assign load_o = start_op;
	assign ready_o = ~busy_r;
	assign read_timeout_o = read_timeout_r;

	// phase order of the bus
	function automatic logic legal_next(hyperram_pkg::bus_state_e from_s,
		hyperram_pkg::bus_state_e to_s);
		case (from_s)
			hyperram_pkg::S_IDLE:    return to_s inside {hyperram_pkg::S_IDLE, hyperram_pkg::S_PRE};
			hyperram_pkg::S_PRE:     return to_s inside {hyperram_pkg::S_PRE, hyperram_pkg::S_CA};
			hyperram_pkg::S_CA:      return to_s inside {hyperram_pkg::S_CA,
				hyperram_pkg::S_LATENCY, hyperram_pkg::S_WRITE};
			hyperram_pkg::S_LATENCY: return to_s inside {hyperram_pkg::S_LATENCY,
				hyperram_pkg::S_WRITE, hyperram_pkg::S_READ};
			hyperram_pkg::S_WRITE:   return to_s inside {hyperram_pkg::S_WRITE, hyperram_pkg::S_POST};
			hyperram_pkg::S_READ:    return to_s inside {hyperram_pkg::S_READ, hyperram_pkg::S_POST};
			hyperram_pkg::S_POST:    return to_s inside {hyperram_pkg::S_POST, hyperram_pkg::S_IDLE};
			default:                 return 1'b0;
		endcase
	endfunction

	a_legal_step: assert property (@(posedge clk_i) disable iff (rst_i)
		legal_next($past(state_r), state_r));

	// the host never sees ready while the bus is in use
	a_busy_on_bus: assert property (@(posedge clk_i) disable iff (rst_i)
		(state_r != hyperram_pkg::S_IDLE) |-> !ready_o);

endmodule

// File: design/hb_dq_driver.sv
`timescale 1ns/100ps

module hb_dq_driver (
	input  logic                     rst_i,
	input  hyperram_pkg::bus_state_e state_i,
	input  hyperram_pkg::cnt_t       cycle_cnt_i,
	input  hyperram_pkg::ca_t        ca_i,
	input  hyperram_pkg::word_t      wdata_i,
	input  hyperram_pkg::sel_t       sel_i,
	output logic                     hb_csn_o,
	output logic                     hb_rwds_o,
	output logic                     hb_rwds_oen_o,
	output logic                     hb_dq_oen_o,
	output hyperram_pkg::byte_t      hb_dq_o
);

	logic in_ca;
	logic in_write;
	logic mem_write;

	assign in_ca = (state_i == hyperram_pkg::S_CA);
	assign in_write = (state_i == hyperram_pkg::S_WRITE);
	// register writes leave rwds to the device
	assign mem_write = in_write && !ca_i[hyperram_pkg::CA_REG_BIT];

	// chip select held high in idle and during reset
	assign hb_csn_o = (state_i == hyperram_pkg::S_IDLE) || rst_i;

	// dq is ours only for command-address and write data
	assign hb_dq_oen_o = in_ca || in_write;
	assign hb_rwds_oen_o = mem_write;
	// rwds high masks the byte, so it is the inverted select
	assign hb_rwds_o = mem_write ? ~sel_i[cycle_cnt_i[1:0]] : 1'b0;

	// counter runs down, so the top byte goes first
	always_comb begin
		hb_dq_o = '0;
		if (in_ca && (cycle_cnt_i < hyperram_pkg::cnt_t'(hyperram_pkg::CA_BYTES))) begin
			hb_dq_o = ca_i[{cycle_cnt_i[2:0], 3'b000} +: 8];
		end else if (in_write && (cycle_cnt_i < hyperram_pkg::cnt_t'(hyperram_pkg::MEM_BYTES))) begin
			// register writes only reach the two low bytes
			hb_dq_o = wdata_i[{cycle_cnt_i[1:0], 3'b000} +: 8];
		end
	end

endmodule

// File: design/hb_read_capture.sv
`timescale 1ns/100ps

module hb_read_capture (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  hyperram_pkg::bus_state_e state_i,
	input  hyperram_pkg::cnt_t       cycle_cnt_i,
	input  logic                     reg_access_i,
	input  logic                     hb_rwds_i,
	input  hyperram_pkg::byte_t      hb_dq_i,
	output logic                     hb_clk_o,
	output logic                     rwds_2x_o,
	output logic                     read_done_o,
	output hyperram_pkg::word_t      rdata_o
);

	logic bus_clk_r;
	logic rwds_r;
	logic rwds_2x_r;
	hyperram_pkg::rcnt_t read_cnt_r;
	hyperram_pkg::word_t rdata_r;
	logic clk_active;
	logic byte_valid;
	logic [1:0] byte_idx;

	// no clock in idle, pre and post, last read edge is not needed
	assign clk_active = (state_i != hyperram_pkg::S_IDLE) && (state_i != hyperram_pkg::S_PRE)
		&& (state_i != hyperram_pkg::S_POST)
		&& !((state_i == hyperram_pkg::S_READ) && (read_cnt_r < 3'd2));

	// odd count takes the rwds level seen one edge earlier
	assign byte_valid = read_cnt_r[0] ? rwds_r : hb_rwds_i;
	// count 4..1 maps to byte 3..0
	assign byte_idx = read_cnt_r[1:0] - 2'd1;

	// everything here moves on the falling edge, half a cycle off the sequencer
	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			bus_clk_r <= 1'b0;
			rwds_r <= 1'b0;
			// device default is double latency
			rwds_2x_r <= 1'b1;
			read_cnt_r <= '0;
		end else begin
			bus_clk_r <= clk_active ? ~bus_clk_r : 1'b0;
			case (state_i)
				hyperram_pkg::S_IDLE: begin
					rwds_2x_r <= 1'b1;
				end
				hyperram_pkg::S_CA: begin
					// device signals its latency on rwds during CA
					if (cycle_cnt_i == hyperram_pkg::cnt_t'(2)) begin
						rwds_2x_r <= hb_rwds_i;
						read_cnt_r <= reg_access_i ? hyperram_pkg::rcnt_t'(hyperram_pkg::REG_BYTES) :
							hyperram_pkg::rcnt_t'(hyperram_pkg::MEM_BYTES);
					end
				end
				hyperram_pkg::S_READ: begin
					rwds_r <= hb_rwds_i;
					if (byte_valid && (read_cnt_r != '0))
						read_cnt_r <= read_cnt_r - 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// read word, cleared at the start of every operation
	always_ff @(negedge clk_i) begin
		if (state_i == hyperram_pkg::S_PRE) begin
			rdata_r <= '0;
		end else if ((state_i == hyperram_pkg::S_READ) && byte_valid && (read_cnt_r != '0)) begin
			rdata_r[{byte_idx, 3'b000} +: 8] <= hb_dq_i;
		end
	end

	assign hb_clk_o = bus_clk_r;
	assign rwds_2x_o = rwds_2x_r;
	assign read_done_o = (read_cnt_r == '0);
	assign rdata_o = rdata_r;

	// bytes only ever get consumed while reading
	a_read_cnt_down: assert property (@(negedge clk_i) disable iff (rst_i)
		((state_i == hyperram_pkg::S_READ) && ($past(state_i) == hyperram_pkg::S_READ))
			|-> (read_cnt_r <= $past(read_cnt_r)));

endmodule

// File: design/hyperram_ctrl.sv
`timescale 1ns/100ps

module hyperram_ctrl #(
	parameter int DEFAULT_TCSH = 4
) (
	input  logic                clk_i,
	input  logic                rst_i,
	// host side
	input  logic                valid_i,
	input  logic                wren_i,
	input  logic                regspace_i,
	input  hyperram_pkg::word_t addr_i,
	input  hyperram_pkg::sel_t  sel_i,
	input  hyperram_pkg::word_t data_i,
	output logic                ready_o,
	output hyperram_pkg::word_t data_o,
	output logic                read_timeout_o,
	// timings, sampled when an operation starts
	input  hyperram_pkg::tim_t  tcsh_i,
	input  hyperram_pkg::tim_t  tpre_i,
	input  hyperram_pkg::tim_t  tacc_i,
	input  hyperram_pkg::tim_t  tpost_i,
	input  hyperram_pkg::tmo_t  trmax_i,
	input  logic                fixed_latency_i,
	input  logic                double_latency_i,
	// hyperbus pins
	output logic                hb_rstn_o,
	output logic                hb_csn_o,
	output logic                hb_clk_o,
	output logic                hb_clkn_o,
	output logic                hb_rwds_o,
	output logic                hb_rwds_oen_o,
	output hyperram_pkg::byte_t hb_dq_o,
	output logic                hb_dq_oen_o,
	input  logic                hb_rwds_i,
	input  hyperram_pkg::byte_t hb_dq_i
);

	hyperram_pkg::bus_state_e state;
	hyperram_pkg::cnt_t cycle_cnt;
	hyperram_pkg::ca_t ca;
	hyperram_pkg::word_t wdata;
	hyperram_pkg::sel_t sel;
	logic load;
	hyperram_pkg::tim_t tcsh;
	hyperram_pkg::tim_t tpost;
	hyperram_pkg::cnt_t latency;
	hyperram_pkg::cnt_t read_tmo;
	logic rwds_2x;
	logic read_done;
	logic bus_clk;

	hb_timing_cfg u_timing_cfg (
		.clk_i(clk_i), .rst_i(rst_i), .load_i(load),
		.tcsh_i(tcsh_i), .tacc_i(tacc_i), .tpost_i(tpost_i), .trmax_i(trmax_i),
		.fixed_latency_i(fixed_latency_i), .double_latency_i(double_latency_i),
		.read_op_i(ca[hyperram_pkg::CA_READ_BIT]), .rwds_2x_i(rwds_2x),
		.tcsh_o(tcsh), .tpost_o(tpost), .latency_o(latency), .read_tmo_o(read_tmo)
	);

	hb_sequencer #(
		.DEFAULT_TCSH(DEFAULT_TCSH)
	) u_sequencer (
		.clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .wren_i(wren_i),
		.regspace_i(regspace_i), .addr_i(addr_i), .data_i(data_i), .sel_i(sel_i),
		.tpre_i(tpre_i), .tcsh_i(tcsh), .tpost_i(tpost),
		.latency_i(latency), .read_tmo_i(read_tmo), .read_done_i(read_done),
		.state_o(state), .cycle_cnt_o(cycle_cnt), .ca_o(ca), .wdata_o(wdata),
		.sel_o(sel), .load_o(load), .ready_o(ready_o), .read_timeout_o(read_timeout_o)
	);

	hb_dq_driver u_dq_driver (
		.rst_i(rst_i), .state_i(state), .cycle_cnt_i(cycle_cnt),
		.ca_i(ca), .wdata_i(wdata), .sel_i(sel),
		.hb_csn_o(hb_csn_o), .hb_rwds_o(hb_rwds_o), .hb_rwds_oen_o(hb_rwds_oen_o),
		.hb_dq_oen_o(hb_dq_oen_o), .hb_dq_o(hb_dq_o)
	);

	hb_read_capture u_read_capture (
		.clk_i(clk_i), .rst_i(rst_i), .state_i(state), .cycle_cnt_i(cycle_cnt),
		.reg_access_i(ca[hyperram_pkg::CA_REG_BIT]),
		.hb_rwds_i(hb_rwds_i), .hb_dq_i(hb_dq_i),
		.hb_clk_o(bus_clk), .rwds_2x_o(rwds_2x), .read_done_o(read_done), .rdata_o(data_o)
	);

	// differential clock pair and active-low device reset
	assign hb_clk_o = bus_clk;
	assign hb_clkn_o = ~bus_clk;
	assign hb_rstn_o = ~rst_i;

endmodule

// File: verification/hyperram_device_model.sv
`timescale 1ns/100ps

module hyperram_device_model (
	input  logic       hb_csn_i,
	input  logic       hb_clk_i,
	input  logic       hb_rwds_i,
	input  logic [7:0] hb_dq_i,
	// access time in bus clocks, already at its legal minimum
	input  logic [3:0] tacc_i,
	input  logic       latency_2x_i,
	input  logic       mute_i,
	output logic       hb_rwds_o,
	output logic       hb_rwds_oen_o,
	output logic [7:0] hb_dq_o,
	output logic       hb_dq_oen_o
);

	logic [31:0] mem [16];
	logic [15:0] cfg_reg = 16'h8f1f;
	logic [47:0] ca = '0;
	logic [31:0] rd_word = '0;
	logic [3:0] idx = '0;
	logic clk_prev = 1'b0;
	logic rwds_q = 1'b0;
	logic rwds_oen_q = 1'b0;
	logic [7:0] dq_q = '0;
	logic dq_oen_q = 1'b0;
	int edge_cnt = 0;
	int lat = 0;
	int nbytes = 4;
	int n = 0;
	int j = 0;

	// power-up contents differ per word
	initial begin
		for (int i = 0; i < 16; i++)
			mem[i] = 32'h5a3c0f00 ^ (i * 32'h01010101);
	end

	// one transfer per bus clock edge, both edges
	always @(hb_clk_i or hb_csn_i) begin
		if (hb_csn_i) begin
			edge_cnt = 0;
			clk_prev = hb_clk_i;
			rwds_oen_q = 1'b0;
			dq_oen_q = 1'b0;
		end else if (hb_clk_i == clk_prev) begin
			// chip select just fell, show the latency multiplier on rwds
			edge_cnt = 0;
			rwds_q = latency_2x_i;
			rwds_oen_q = !mute_i;
		end else begin
			clk_prev = hb_clk_i;
			edge_cnt++;
			n = edge_cnt - 6;
			if (edge_cnt <= 6)
				ca = {ca[39:0], hb_dq_i};
			if (edge_cnt == 6) begin
				// command-address complete
				rwds_oen_q = 1'b0;
				idx = {ca[16], ca[2:0]};
				lat = (latency_2x_i ? 4 : 2) * int'(tacc_i);
				nbytes = ca[46] ? 2 : 4;
				rd_word = ca[46] ? {16'h0000, cfg_reg} : mem[idx];
			end else if ((n > 0) && !ca[47]) begin
				if (ca[46]) begin
					// register writes carry no latency
					if (n <= 2)
						cfg_reg[8 * (2 - n) +: 8] = hb_dq_i;
				end else if ((n >= lat - 1) && (n <= lat + 2)) begin
					j = n - (lat - 1);
					// rwds high masks the byte
					if (!hb_rwds_i)
						mem[idx][8 * (3 - j) +: 8] = hb_dq_i;
				end
			end else if ((n > 0) && !mute_i) begin
				if ((n >= lat) && (n < lat + nbytes)) begin
					j = n - lat;
					dq_q = rd_word[8 * (nbytes - 1 - j) +: 8];
					// strobe toggles with each byte, high on the first
					rwds_q = (j % 2 == 0);
					dq_oen_q = 1'b1;
					rwds_oen_q = 1'b1;
				end else if (n >= lat + nbytes) begin
					dq_oen_q = 1'b0;
					rwds_oen_q = 1'b0;
				end
			end
		end
	end

	assign hb_rwds_o = rwds_q;
	assign hb_rwds_oen_o = rwds_oen_q;
	assign hb_dq_o = dq_q;
	assign hb_dq_oen_o = dq_oen_q;

endmodule

// File: verification/tb_hyperram.sv
`timescale 1ns/100ps

module tb_hyperram;

	localparam int CLK_PERIOD = 100;
	localparam int N_OPS = 21;

	logic clk_i;
	logic rst_i;
	logic valid;
	logic wren;
	logic regspace;
	logic [31:0] addr;
	logic [31:0] data;
	logic [3:0] sel;
	logic ready;
	logic [31:0] data_o;
	logic read_timeout;
	logic [3:0] tcsh;
	logic [3:0] tpre;
	logic [3:0] tacc;
	logic [3:0] tpost;
	logic [4:0] trmax;
	logic fixed_latency;
	logic double_latency;
	logic hb_rstn;
	logic hb_csn;
	logic hb_clk;
	logic hb_clkn;
	logic dut_rwds;
	logic dut_rwds_oen;
	logic [7:0] dut_dq;
	logic dut_dq_oen;
	logic dev_rwds;
	logic dev_rwds_oen;
	logic [7:0] dev_dq;
	logic dev_dq_oen;
	logic rwds_bus;
	logic [7:0] dq_bus;
	logic dev_2x;
	logic dev_mute;
	logic [3:0] dev_tacc;
	logic [31:0] rng;
	logic [31:0] sb [16];
	// bus monitor state
	int csn_high_cnt = 0;
	int gap_min = 4;
	int gap_cnt = 0;
	int gap_phase = 0;
	int gap_checks = 0;
	logic measure_gap = 1'b0;
	int exp_gap = 0;

	hyperram_ctrl #(
		.DEFAULT_TCSH(4)
	) u_hyperram_ctrl (
		.clk_i(clk_i), .rst_i(rst_i), .valid_i(valid), .wren_i(wren),
		.regspace_i(regspace), .addr_i(addr), .sel_i(sel), .data_i(data),
		.ready_o(ready), .data_o(data_o), .read_timeout_o(read_timeout),
		.tcsh_i(tcsh), .tpre_i(tpre), .tacc_i(tacc), .tpost_i(tpost), .trmax_i(trmax),
		.fixed_latency_i(fixed_latency), .double_latency_i(double_latency),
		.hb_rstn_o(hb_rstn), .hb_csn_o(hb_csn), .hb_clk_o(hb_clk), .hb_clkn_o(hb_clkn),
		.hb_rwds_o(dut_rwds), .hb_rwds_oen_o(dut_rwds_oen), .hb_dq_o(dut_dq),
		.hb_dq_oen_o(dut_dq_oen), .hb_rwds_i(rwds_bus), .hb_dq_i(dq_bus)
	);

	hyperram_device_model u_device (
		.hb_csn_i(hb_csn), .hb_clk_i(hb_clk), .hb_rwds_i(rwds_bus), .hb_dq_i(dq_bus),
		.tacc_i(dev_tacc), .latency_2x_i(dev_2x), .mute_i(dev_mute),
		.hb_rwds_o(dev_rwds), .hb_rwds_oen_o(dev_rwds_oen),
		.hb_dq_o(dev_dq), .hb_dq_oen_o(dev_dq_oen)
	);

	// shared bus lines, controller wins when both enable
	assign rwds_bus = dut_rwds_oen ? dut_rwds : (dev_rwds_oen ? dev_rwds : 1'b0);
	assign dq_bus = dut_dq_oen ? dut_dq : (dev_dq_oen ? dev_dq : 8'h00);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic fail_with(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else
			fail_with($sformatf("[FAIL] t=%0t %s got 0x%0h expected 0x%0h",
				$time, name, got, exp));
	endtask

	// one host operation, returns once ready_o is back
	task automatic run_op(input logic wr, input logic reg_op, input logic [31:0] a,
		input logic [31:0] d, input logic [3:0] s);
		rng = xorshift32(rng);
		@(posedge clk_i);
		#1;
		tcsh = rng[3:0];
		tpre = {2'b00, rng[5:4]};
		tpost = {2'b00, rng[7:6]};
		valid = 1'b1;
		wren = wr;
		regspace = reg_op;
		addr = a;
		data = d;
		sel = s;
		@(posedge clk_i);
		#1;
		valid = 1'b0;
		@(negedge clk_i);
		while (!ready)
			@(negedge clk_i);
	endtask

	// masked write then read back under one latency setup
	task automatic write_read_mem(input logic fixed, input logic dbl, input logic m2x,
		input logic [3:0] tacc_v);
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0] s;
		logic [3:0] idx;
		logic [3:0] tacc_eff;
		int lat_l;
		int checks_before;
		rng = xorshift32(rng);
		a = rng;
		idx = a[3:0];
		rng = xorshift32(rng);
		d = rng;
		rng = xorshift32(rng);
		s = rng[3:0];
		tacc_eff = (tacc_v < 4'd2) ? 4'd2 : tacc_v;
		@(posedge clk_i);
		#1;
		fixed_latency = fixed;
		double_latency = dbl;
		tacc = tacc_v;
		dev_2x = m2x;
		dev_tacc = tacc_eff;
		// write latency, one short of the read latency
		lat_l = (((fixed ? dbl : m2x) ? 4 : 2) * int'(tacc_eff)) - 2 - 1;
		exp_gap = lat_l + 1;
		measure_gap = 1'b1;
		checks_before = gap_checks;
		run_op(1'b1, 1'b0, a, d, s);
		measure_gap = 1'b0;
		check_value("latency gap measurements", gap_checks, checks_before + 1);
		for (int k = 0; k < 4; k++)
			if (s[k])
				sb[idx][8 * k +: 8] = d[8 * k +: 8];
		run_op(1'b0, 1'b0, a, 32'h0, 4'h0);
		check_value("data_o", data_o, sb[idx]);
		check_value("read_timeout_o", read_timeout, 0);
	endtask

	task automatic write_read_reg();
		logic [31:0] d;
		rng = xorshift32(rng);
		d = rng;
		run_op(1'b1, 1'b1, 32'h0, d, 4'hf);
		run_op(1'b0, 1'b1, 32'h0, 32'h0, 4'h0);
		check_value("data_o", data_o, {16'h0000, d[15:0]});
		check_value("read_timeout_o", read_timeout, 0);
	endtask

	// device stays silent, controller has to give up
	task automatic muted_read();
		@(posedge clk_i);
		#1;
		fixed_latency = 1'b1;
		double_latency = 1'b0;
		dev_2x = 1'b0;
		tacc = 4'd2;
		dev_tacc = 4'd2;
		trmax = 5'd1;
		dev_mute = 1'b1;
		run_op(1'b0, 1'b0, 32'h5, 32'h0, 4'h0);
		check_value("read_timeout_o", read_timeout, 1);
		check_value("data_o", data_o, 32'h0);
		@(posedge clk_i);
		#1;
		dev_mute = 1'b0;
		trmax = 5'd10;
	endtask

	// cs high time between operations and the latency gap of writes
	always @(negedge clk_i) begin
		if (!rst_i) begin
			if (hb_csn) begin
				csn_high_cnt++;
				gap_phase = 0;
				gap_cnt = 0;
			end else begin
				if (csn_high_cnt > 0) begin
					assert (csn_high_cnt >= gap_min + 1) else
						fail_with($sformatf("[FAIL] t=%0t hb_csn_o high cycles got %0d expected %0d",
							$time, csn_high_cnt, gap_min + 1));
					// this operation's tcsh sets the next gap
					gap_min = int'(tcsh);
					csn_high_cnt = 0;
				end
				if (dut_dq_oen) begin
					if (gap_phase == 0) begin
						gap_phase = 1;
					end else if (gap_phase == 2) begin
						if (measure_gap) begin
							check_value("hb_dq_oen_o low cycles", gap_cnt, exp_gap);
							gap_checks++;
						end
						gap_phase = 3;
					end
				end else if (gap_phase == 1) begin
					gap_phase = 2;
					gap_cnt = 1;
				end else if (gap_phase == 2) begin
					gap_cnt++;
				end
			end
		end
	end

	ready_off_bus: assert property (@(negedge clk_i) disable iff (rst_i) !hb_csn |-> !ready)
		else fail_with($sformatf("[FAIL] t=%0t ready_o got %b expected 0", $time, ready));

	// differential pair stays complementary, sampled away from its edges
	clk_pair: assert property (@(posedge clk_i) hb_clkn === ~hb_clk)
		else fail_with($sformatf("[FAIL] t=%0t hb_clkn_o got %b expected %b",
			$time, hb_clkn, ~hb_clk));

	initial begin
		#(N_OPS * 200 * CLK_PERIOD);
		fail_with("watchdog expired, the operations did not complete in the allowed time");
	end

	initial begin
		rst_i = 1'b1;
		valid = 1'b0;
		wren = 1'b0;
		regspace = 1'b0;
		addr = '0;
		data = '0;
		sel = '0;
		tcsh = 4'd4;
		tpre = 4'd1;
		tacc = 4'd2;
		tpost = 4'd1;
		trmax = 5'd10;
		fixed_latency = 1'b1;
		double_latency = 1'b0;
		dev_2x = 1'b0;
		dev_mute = 1'b0;
		dev_tacc = 4'd2;
		rng = 32'h0fa45b2a;
		for (int i = 0; i < 16; i++)
			sb[i] = 32'h5a3c0f00 ^ (i * 32'h01010101);
		repeat (10) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		@(negedge clk_i);
		check_value("ready_o", ready, 1);
		check_value("hb_csn_o", hb_csn, 1);
		check_value("hb_rstn_o", hb_rstn, 1);
		check_value("hb_rwds_oen_o", dut_rwds_oen, 0);
		check_value("hb_dq_oen_o", dut_dq_oen, 0);
		// fixed single, fixed double, variable with both device settings
		repeat (2) begin
			write_read_mem(1'b1, 1'b0, 1'b0, 4'd3);
			write_read_mem(1'b1, 1'b1, 1'b1, 4'd2);
			write_read_mem(1'b0, 1'b0, 1'b0, 4'd1);
			write_read_mem(1'b0, 1'b0, 1'b1, 4'd3);
		end
		write_read_reg();
		muted_read();
		// back to normal after a timeout
		write_read_mem(1'b0, 1'b1, 1'b1, 4'd2);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_hyperram
FILELIST = project.f

SRCS = $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: project.f
design/hyperram_pkg.sv
design/hb_timing_cfg.sv
design/hb_sequencer.sv
design/hb_dq_driver.sv
design/hb_read_capture.sv
design/hyperram_ctrl.sv
verification/hyperram_device_model.sv
verification/tb_hyperram.sv
